/* hdl/switch_config.svh */
`ifndef SWITCH_CONFIG_SVH
`define SWITCH_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// Switch dimensions
////////////////////////////////////////////////////////////////////////////

// Number of byte-wide switch ports
`define SW_NUM_PORTS        4

// Words held by each ingress queue
`define SW_QUEUE_DEPTH      64

// Learned MAC entries
`define SW_CAM_DEPTH        16

// Destination MAC followed by source MAC
`define SW_MAC_BYTES        6
`define SW_HEADER_BYTES     12

`endif

/* hdl/switch_pkg.sv */
`include "switch_config.svh"

package switch_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Stream and forwarding types
    ////////////////////////////////////////////////////////////////////////////

    // One byte of a frame, last flag marks the final byte
    typedef struct packed {
        logic       last;
        logic [7:0] data;
    } word_t;

    // Port number
    typedef logic [$clog2(`SW_NUM_PORTS)-1:0] port_idx_t;

    // One bit per port
    typedef logic [`SW_NUM_PORTS-1:0] port_mask_t;

    // Station address, first byte on the wire in the top bits
    typedef logic [8*`SW_MAC_BYTES-1:0] mac_t;

endpackage

/* hdl/port_rx_queue.sv */
`timescale 1ns/1ps
`include "switch_config.svh"

module port_rx_queue
    import switch_pkg::*;
#(
    parameter int DEPTH = `SW_QUEUE_DEPTH
) (
    input  logic    clock,
    input  logic    rst_n,
    input  word_t   in_data,
    input  logic    in_valid,
    output logic    in_ready,
    input  logic    pop,
    output word_t   head_data,
    output logic    head_valid,
    output logic    frame_avail
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    word_t          mem [DEPTH];
    logic [AW-1:0]  wr_ptr;
    logic [AW-1:0]  rd_ptr;
    logic [CW-1:0]  count;
    logic [CW-1:0]  count_next;
    logic [CW-1:0]  frames;
    logic           push;
    logic           take;

    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
        return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign push = in_valid && in_ready;
    assign take = pop && head_valid;

    always_comb begin
        count_next = count;
        case ({push, take})
            2'b10:   count_next = count + 1'b1;
            2'b01:   count_next = count - 1'b1;
            default: count_next = count;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            frames   <= '0;
            in_ready <= 1'b0;
        end else begin
            if (push) wr_ptr <= next_ptr(wr_ptr);
            if (take) rd_ptr <= next_ptr(rd_ptr);
            count    <= count_next;
            in_ready <= (count_next != CW'(DEPTH));
            // Complete frames stored
            case ({push && in_data.last, take && head_data.last})
                2'b10:   frames <= frames + 1'b1;
                2'b01:   frames <= frames - 1'b1;
                default: frames <= frames;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (push) mem[wr_ptr] <= in_data;
    end

    assign head_data   = mem[rd_ptr];
    assign head_valid  = (count != '0);
    assign frame_avail = (frames != '0);

endmodule

/* hdl/cam_table.sv */
`timescale 1ns/1ps
`include "switch_config.svh"

module cam_table
    import switch_pkg::*;
#(
    parameter int DEPTH = `SW_CAM_DEPTH
) (
    input  logic        clock,
    input  logic        rst_n,
    input  logic        learn,
    input  mac_t        learn_mac,
    input  port_idx_t   learn_port,
    input  logic        lookup,
    input  mac_t        lookup_mac,
    output logic        hit,
    output port_idx_t   hit_port
);

    localparam int IW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [DEPTH-1:0]   entry_valid;
    mac_t               entry_key  [DEPTH];
    port_idx_t          entry_port [DEPTH];
    logic [IW-1:0]      repl_ptr;

    logic               do_learn;
    logic               learn_found;
    logic [IW-1:0]      learn_idx;
    logic               lookup_found;
    port_idx_t          lookup_port;

    ////////////////////////////////////////////////////////////////////////////
    // Parallel compare of every valid entry
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        learn_found  = 1'b0;
        learn_idx    = '0;
        lookup_found = 1'b0;
        lookup_port  = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (entry_valid[i] && (entry_key[i] == learn_mac)) begin
                learn_found = 1'b1;
                learn_idx   = IW'(i);
            end
            if (entry_valid[i] && (entry_key[i] == lookup_mac)) begin
                lookup_found = 1'b1;
                lookup_port  = entry_port[i];
            end
        end
    end

    // Broadcast address is never stored
    assign do_learn = learn && (learn_mac != '1);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            entry_valid <= '0;
            repl_ptr    <= '0;
        end else if (do_learn && !learn_found) begin
            entry_valid[repl_ptr] <= 1'b1;
            repl_ptr <= (repl_ptr == IW'(DEPTH - 1)) ? '0 : repl_ptr + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (do_learn) begin
            if (learn_found) begin
                // Station moved, keep the slot
                entry_port[learn_idx] <= learn_port;
            end else begin
                entry_key[repl_ptr]  <= learn_mac;
                entry_port[repl_ptr] <= learn_port;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            hit <= 1'b0;
        end else begin
            hit <= lookup && lookup_found;
        end
    end

    always_ff @(posedge clock) begin
        if (lookup) hit_port <= lookup_port;
    end

endmodule

/* hdl/core_data_orchestrator.sv */
`timescale 1ns/1ps
`include "switch_config.svh"

module core_data_orchestrator
    import switch_pkg::*;
(
    input  logic                        clock,
    input  logic                        rst_n,
    input  port_mask_t                  frame_avail,
    input  word_t [`SW_NUM_PORTS-1:0]   head_data,
    input  port_mask_t                  head_valid,
    input  logic                        hit,
    input  port_idx_t                   hit_port,
    input  logic                        fwd_ready,
    output port_mask_t                  pop,
    output logic                        learn,
    output mac_t                        learn_mac,
    output port_idx_t                   learn_port,
    output logic                        lookup,
    output mac_t                        lookup_mac,
    output word_t                       fwd_data,
    output port_mask_t                  fwd_mask,
    output logic                        fwd_valid
);

    localparam int NP = `SW_NUM_PORTS;
    localparam int HB = `SW_HEADER_BYTES;
    localparam int MB = `SW_MAC_BYTES;
    localparam int BW = $clog2(HB);

    typedef enum logic [2:0] {
        S_SELECT,
        S_HEADER,
        S_LOOKUP,
        S_DECIDE,
        S_REPLAY,
        S_STREAM,
        S_DROP
    } state_t;

    state_t         state;
    port_idx_t      cur_port;
    logic [BW-1:0]  byte_cnt;
    logic [7:0]     hdr [HB];
    port_mask_t     mask_q;

    logic           sel_found;
    port_idx_t      sel_port;
    port_mask_t     cur_onehot;
    port_mask_t     decide_mask;
    word_t          cur_head;
    logic           cur_valid;
    logic           head_take;
    logic           byte_done;

    ////////////////////////////////////////////////////////////////////////////
    // Round-robin pick, starting after the port served last
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        int idx;
        sel_found = 1'b0;
        sel_port  = '0;
        // Descending so the nearest candidate wins
        for (int k = NP; k >= 1; k--) begin
            idx = (int'(cur_port) + k) % NP;
            if (frame_avail[idx]) begin
                sel_found = 1'b1;
                sel_port  = port_idx_t'(idx);
            end
        end
    end

    assign cur_head   = head_data[cur_port];
    assign cur_valid  = head_valid[cur_port];
    assign cur_onehot = port_mask_t'(1) << cur_port;
    assign byte_done  = (byte_cnt == BW'(HB - 1));

    // Self-addressed frames get an empty mask
    always_comb begin
        if (!hit) begin
            decide_mask = ~cur_onehot;
        end else if (hit_port == cur_port) begin
            decide_mask = '0;
        end else begin
            decide_mask = port_mask_t'(1) << hit_port;
        end
    end

    always_comb begin
        for (int b = 0; b < MB; b++) begin
            lookup_mac[8*(MB-1-b) +: 8] = hdr[b];
            learn_mac[8*(MB-1-b) +: 8]  = hdr[MB + b];
        end
    end

    assign learn      = (state == S_LOOKUP);
    assign lookup     = (state == S_LOOKUP);
    assign learn_port = cur_port;
    assign fwd_mask   = mask_q;

    always_comb begin
        fwd_valid = 1'b0;
        fwd_data  = cur_head;
        head_take = 1'b0;
        case (state)
            S_HEADER: begin
                head_take = cur_valid;
            end
            S_REPLAY: begin
                fwd_valid = 1'b1;
                fwd_data  = '{last: 1'b0, data: hdr[byte_cnt]};
            end
            S_STREAM: begin
                fwd_valid = cur_valid;
                head_take = cur_valid && fwd_ready;
            end
            S_DROP: begin
                head_take = cur_valid;
            end
            default: begin
                head_take = 1'b0;
            end
        endcase
    end

    assign pop = head_take ? cur_onehot : '0;

    ////////////////////////////////////////////////////////////////////////////
    // Frame FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state    <= S_SELECT;
            cur_port <= port_idx_t'(NP - 1);
            byte_cnt <= '0;
            mask_q   <= '0;
        end else begin
            case (state)
                S_SELECT: begin
                    if (sel_found) begin
                        cur_port <= sel_port;
                        byte_cnt <= '0;
                        state    <= S_HEADER;
                    end
                end
                S_HEADER: begin
                    if (head_take) begin
                        byte_cnt <= byte_done ? '0 : byte_cnt + 1'b1;
                        if (byte_done) state <= S_LOOKUP;
                    end
                end
                S_LOOKUP: begin
                    state <= S_DECIDE;
                end
                S_DECIDE: begin
                    mask_q <= decide_mask;
                    state  <= (decide_mask == '0) ? S_DROP : S_REPLAY;
                end
                S_REPLAY: begin
                    if (fwd_ready) begin
                        byte_cnt <= byte_done ? '0 : byte_cnt + 1'b1;
                        if (byte_done) state <= S_STREAM;
                    end
                end
                S_STREAM, S_DROP: begin
                    if (head_take && cur_head.last) state <= S_SELECT;
                end
                default: begin
                    state <= S_SELECT;
                end
            endcase
        end
    end

    // Header bytes kept for lookup and replay
    always_ff @(posedge clock) begin
        if ((state == S_HEADER) && head_take) hdr[byte_cnt] <= cur_head.data;
    end

endmodule

/* hdl/egress_fanout.sv */
`timescale 1ns/1ps

module egress_fanout
    import switch_pkg::*;
(
    input  logic        clock,
    input  logic        rst_n,
    input  word_t       fwd_data,
    input  port_mask_t  fwd_mask,
    input  logic        fwd_valid,
    output logic        fwd_ready,
    input  port_mask_t  tx_ready,
    output word_t       tx_data,
    output port_mask_t  tx_valid
);

    // Ports still owed the held word
    port_mask_t pending;

    assign fwd_ready = (pending == '0);
    assign tx_valid  = pending;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pending <= '0;
        end else if (fwd_valid && fwd_ready) begin
            pending <= fwd_mask;
        end else begin
            // Each port drops out on its own handshake
            pending <= pending & ~tx_ready;
        end
    end

    always_ff @(posedge clock) begin
        if (fwd_valid && fwd_ready) tx_data <= fwd_data;
    end

endmodule

/* hdl/switch_core.sv */
`timescale 1ns/1ps
`include "switch_config.svh"

module switch_core
    import switch_pkg::*;
(
    input  logic                        clock,
    input  logic                        rst_n,
    input  word_t [`SW_NUM_PORTS-1:0]   rx_data,
    input  port_mask_t                  rx_valid,
    output port_mask_t                  rx_ready,
    output word_t                       tx_data,
    output port_mask_t                  tx_valid,
    input  port_mask_t                  tx_ready
);

    word_t [`SW_NUM_PORTS-1:0]  head_data;
    port_mask_t                 head_valid;
    port_mask_t                 frame_avail;
    port_mask_t                 pop;

    logic                       learn;
    mac_t                       learn_mac;
    port_idx_t                  learn_port;
    logic                       lookup;
    mac_t                       lookup_mac;
    logic                       hit;
    port_idx_t                  hit_port;

    word_t                      fwd_data;
    port_mask_t                 fwd_mask;
    logic                       fwd_valid;
    logic                       fwd_ready;

    ////////////////////////////////////////////////////////////////////////////
    // Ingress queues
    ////////////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < `SW_NUM_PORTS; i++) begin : g_port
        port_rx_queue #(
            .DEPTH          (`SW_QUEUE_DEPTH)
        ) rx_queue_i (
            .clock          (clock),
            .rst_n          (rst_n),
            .in_data        (rx_data[i]),
            .in_valid       (rx_valid[i]),
            .in_ready       (rx_ready[i]),
            .pop            (pop[i]),
            .head_data      (head_data[i]),
            .head_valid     (head_valid[i]),
            .frame_avail    (frame_avail[i])
        );
    end

    core_data_orchestrator orchestrator_i (
        .clock          (clock),
        .rst_n          (rst_n),
        .frame_avail    (frame_avail),
        .head_data      (head_data),
        .head_valid     (head_valid),
        .hit            (hit),
        .hit_port       (hit_port),
        .fwd_ready      (fwd_ready),
        .pop            (pop),
        .learn          (learn),
        .learn_mac      (learn_mac),
        .learn_port     (learn_port),
        .lookup         (lookup),
        .lookup_mac     (lookup_mac),
        .fwd_data       (fwd_data),
        .fwd_mask       (fwd_mask),
        .fwd_valid      (fwd_valid)
    );

    cam_table #(
        .DEPTH          (`SW_CAM_DEPTH)
    ) cam_table_i (
        .clock          (clock),
        .rst_n          (rst_n),
        .learn          (learn),
        .learn_mac      (learn_mac),
        .learn_port     (learn_port),
        .lookup         (lookup),
        .lookup_mac     (lookup_mac),
        .hit            (hit),
        .hit_port       (hit_port)
    );

    egress_fanout fanout_i (
        .clock          (clock),
        .rst_n          (rst_n),
        .fwd_data       (fwd_data),
        .fwd_mask       (fwd_mask),
        .fwd_valid      (fwd_valid),
        .fwd_ready      (fwd_ready),
        .tx_ready       (tx_ready),
        .tx_data        (tx_data),
        .tx_valid       (tx_valid)
    );

endmodule

/* verif/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD_NS    = 4.0,
    parameter int  RESET_CYCLES = 16
) (
    output logic clock,
    output logic rst_n
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD_NS / 2.0) clock = ~clock;
    end

    // Release just after an edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        rst_n = 1'b1;
    end

endmodule

/* verif/switch_core_checker.sv */
`timescale 1ns/1ps

module switch_core_checker
    import switch_pkg::*;
(
    input  logic        clock,
    input  logic        rst_n,
    input  word_t       tx_data,
    input  port_mask_t  tx_valid,
    input  port_mask_t  tx_ready,
    input  port_mask_t  rx_ready
);

    int     failures = 0;
    logic   in_reset;

    // Reset seen at the previous edge as well
    always_ff @(posedge clock) begin
        in_reset <= !rst_n;
    end

    tx_data_held: assert property (@(posedge clock) disable iff (!rst_n)
        |(tx_valid & ~tx_ready) |=> $stable(tx_data))
    else begin
        failures++;
        $error("tx_data changed while a port still owed its handshake");
    end

    tx_idle_in_reset: assert property (@(posedge clock)
        (!rst_n && in_reset) |-> (tx_valid == '0))
    else begin
        failures++;
        $error("tx_valid high during reset");
    end

    rx_closed_in_reset: assert property (@(posedge clock)
        (!rst_n && in_reset) |-> (rx_ready == '0))
    else begin
        failures++;
        $error("rx_ready high during reset");
    end

endmodule

/* verif/switch_core_tb.sv */
`timescale 1ns/1ps
`include "switch_config.svh"

module switch_core_tb
    import switch_pkg::*;
();

    localparam int   NP      = `SW_NUM_PORTS;
    localparam int   MIN_LEN = 14;
    localparam int   MAX_LEN = 60;
    localparam int   NFRAMES = 128;
    localparam int   BURST   = 6;
    localparam mac_t UNKNOWN = 48'h02_00_5e_00_ff_ee;

    logic           clock;
    logic           rst_n;
    word_t [NP-1:0] rx_data;
    port_mask_t     rx_valid;
    port_mask_t     rx_ready;
    word_t          tx_data;
    port_mask_t     tx_valid;
    port_mask_t     tx_ready;

    integer         seed = 32'h63d9fd86;
    logic [7:0]     frame_mem [NFRAMES][MAX_LEN];
    int             frame_len [NFRAMES];
    bit             expected [NP][NFRAMES];
    int             frame_count = 0;
    mac_t           model_mac [32];
    int             model_port [32];
    int             model_size = 0;
    logic [7:0]     rx_buf [NP][MAX_LEN];
    int             rx_len [NP];
    int             burst_ids [NP][BURST];
    mac_t           station [NP];
    int             errors = 0;
    int             checks = 0;
    int             cycle_count = 0;
    int             bytes_sent = 0;
    int             test_bytes = 0;
    int             test_errors = 0;
    int             tests_run = 0;
    int             tests_failed = 0;
    bit             stall_mode = 1'b0;
    bit             track_bp = 1'b0;
    bit             saw_bp = 1'b0;

    tb_clock_gen clock_gen_i (
        .clock      (clock),
        .rst_n      (rst_n)
    );

    switch_core switch_core_i (
        .clock      (clock),
        .rst_n      (rst_n),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .rx_ready   (rx_ready),
        .tx_data    (tx_data),
        .tx_valid   (tx_valid),
        .tx_ready   (tx_ready)
    );

    bind switch_core switch_core_checker checker_i (
        .clock      (clock),
        .rst_n      (rst_n),
        .tx_data    (tx_data),
        .tx_valid   (tx_valid),
        .tx_ready   (tx_ready),
        .rx_ready   (rx_ready)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Reference forwarding model
    ////////////////////////////////////////////////////////////////////////////

    // Lookup sees the table before this frame's own source is learned
    function automatic port_mask_t expected_mask(input mac_t dst, input int ingress);
        port_mask_t m;
        m = ~(port_mask_t'(1) << ingress);
        for (int i = 0; i < model_size; i++) begin
            if (model_mac[i] == dst) begin
                m = (model_port[i] == ingress) ? '0 : port_mask_t'(1) << model_port[i];
            end
        end
        return m;
    endfunction

    function automatic void model_learn(input mac_t src, input int port);
        int slot;
        slot = model_size;
        for (int i = 0; i < model_size; i++) begin
            if (model_mac[i] == src) slot = i;
        end
        if (src != '1) begin
            model_mac[slot]  = src;
            model_port[slot] = port;
            if (slot == model_size) model_size++;
        end
    endfunction

    // Bytes 12 and 13 carry the frame id
    task automatic prepare_frame(input mac_t dst, input mac_t src, input int ingress,
                                 output int id);
        port_mask_t mask;
        id = frame_count;
        frame_count++;
        frame_len[id] = MIN_LEN + $unsigned($random(seed)) % (MAX_LEN - MIN_LEN + 1);
        for (int b = 0; b < frame_len[id]; b++) begin
            if (b < 6) frame_mem[id][b] = dst[8*(5-b) +: 8];
            else if (b < 12) frame_mem[id][b] = src[8*(11-b) +: 8];
            else if (b == 12) frame_mem[id][b] = 8'(id >> 8);
            else if (b == 13) frame_mem[id][b] = 8'(id);
            else frame_mem[id][b] = 8'($random(seed));
        end
        mask = expected_mask(dst, ingress);
        model_learn(src, ingress);
        for (int q = 0; q < NP; q++) begin
            if (mask[q]) expected[q][id] = 1'b1;
        end
        bytes_sent += frame_len[id];
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic send_frame(input int port, input int id);
        for (int b = 0; b < frame_len[id]; b++) begin
            rx_data[port].data = frame_mem[id][b];
            rx_data[port].last = (b == frame_len[id] - 1);
            rx_valid[port]     = 1'b1;
            @(negedge clock);
            while (!rx_ready[port]) begin
                if (track_bp) saw_bp = 1'b1;
                @(negedge clock);
            end
            @(posedge clock);
            #1;
        end
        rx_valid[port] = 1'b0;
    endtask

    task automatic send_one(input mac_t dst, input mac_t src, input int ingress);
        int id;
        prepare_frame(dst, src, ingress, id);
        send_frame(ingress, id);
    endtask

    task automatic send_burst(input int port);
        for (int i = 0; i < BURST; i++) begin
            send_frame(port, burst_ids[port][i]);
        end
    endtask

    always @(posedge clock) begin
        #1;
        tx_ready = stall_mode ? port_mask_t'($random(seed)) : '1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Egress collection and compare
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_frame(input int p);
        int id;
        id = (rx_len[p] >= MIN_LEN) ? {rx_buf[p][12], rx_buf[p][13]} : NFRAMES;
        checks++;
        if (id >= frame_count) begin
            $display("Frame of %0d bytes on port %0d at %0t has no known id",
                     rx_len[p], p, $time);
            errors++;
        end else if (!expected[p][id]) begin
            $display("Frame %0d arrived on port %0d where it was not expected", id, p);
            errors++;
        end else begin
            expected[p][id] = 1'b0;
            if (rx_len[p] != frame_len[id]) begin
                $display("** Error at %0t: tx_data frame %0d port %0d length %0d, expected %0d",
                         $time, id, p, rx_len[p], frame_len[id]);
                errors++;
            end else begin
                for (int b = 0; b < rx_len[p]; b++) begin
                    if (rx_buf[p][b] !== frame_mem[id][b]) begin
                        $display("** Error at %0t: tx_data %s is 0x%02h, expected 0x%02h",
                                 $time, $sformatf("port %0d frame %0d byte %0d", p, id, b),
                                 rx_buf[p][b], frame_mem[id][b]);
                        errors++;
                    end
                end
            end
        end
    endtask

    // Handshake values are settled at the falling edge
    always @(negedge clock) begin
        if (rst_n) begin
            for (int p = 0; p < NP; p++) begin
                if (tx_valid[p] && tx_ready[p]) begin
                    if (rx_len[p] < MAX_LEN) rx_buf[p][rx_len[p]] = tx_data.data;
                    rx_len[p]++;
                    if (tx_data.last) begin
                        check_frame(p);
                        rx_len[p] = 0;
                    end
                end
            end
        end
    end

    function automatic int outstanding();
        int n;
        n = 0;
        for (int q = 0; q < NP; q++) begin
            for (int id = 0; id < frame_count; id++) n += expected[q][id];
        end
        return n;
    endfunction

    task automatic wait_drained();
        int limit;
        int waited;
        limit  = 4 * NP * (bytes_sent - test_bytes) + 500;
        waited = 0;
        while (outstanding() != 0 && waited < limit) begin
            @(posedge clock);
            waited++;
        end
        for (int q = 0; q < NP; q++) begin
            for (int id = 0; id < frame_count; id++) begin
                if (expected[q][id]) begin
                    $display("Frame %0d never arrived on port %0d", id, q);
                    expected[q][id] = 1'b0;
                    errors++;
                end
            end
        end
        // Room for stray copies to show up
        repeat (20) @(posedge clock);
        #1;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != test_errors) tests_failed++;
        $display("Test %0d, %s: %s", tests_run, name,
                 (errors == test_errors) ? "ok" : "errors found");
        test_errors = errors;
        test_bytes  = bytes_sent;
    endtask

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > 4 * NP * bytes_sent + 2000) begin
            $display("Run stopped after %0d cycles without finishing", cycle_count);
            $display("TEST FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int q;
        rx_data  = '0;
        rx_valid = '0;
        tx_ready = '1;
        for (int p = 0; p < NP; p++) begin
            station[p] = 48'h02_00_5e_00_00_10 + p;
            rx_len[p]  = 0;
        end
        wait (rst_n === 1'b1);
        @(posedge clock);
        #1;
        stall_mode = 1'b1;

        send_one(UNKNOWN, station[1], 1);
        wait_drained();
        end_test("unknown destination flood");

        for (int p = 0; p < NP; p++) send_one(UNKNOWN, station[p], p);
        wait_drained();
        for (int p = 0; p < NP; p++) send_one(station[(p + 2) % NP], station[p], p);
        wait_drained();
        end_test("learned destination unicast");

        // Self-addressed frame with a marker behind it
        send_one(station[0], station[0], 0);
        send_one(station[1], station[0], 0);
        wait_drained();
        end_test("same port drop");

        for (int k = 0; k < 6; k++) begin
            send_one(station[k % NP], 48'h02_00_5e_00_01_00 + k, (k + 1) % NP);
        end
        wait_drained();
        for (int p = 0; p < NP; p++) send_one('1, station[p], p);
        wait_drained();
        end_test("broadcast flood");

        track_bp = 1'b1;
        for (int p = 0; p < NP; p++) begin
            for (int i = 0; i < BURST; i++) begin
                q = (p + 1 + $unsigned($random(seed)) % (NP - 1)) % NP;
                prepare_frame(station[q], station[p], p, burst_ids[p][i]);
            end
        end
        for (int p = 0; p < NP; p++) begin
            fork
                automatic int port = p;
                send_burst(port);
            join_none
        end
        wait fork;
        wait_drained();
        track_bp = 1'b0;
        checks++;
        if (!saw_bp) begin
            $display("rx_ready never dropped during the stalled bursts");
            errors++;
        end
        end_test("concurrent bursts with stalls");

        // Station 3 moves to port 1
        send_one(station[0], station[3], 1);
        wait_drained();
        send_one(station[3], station[0], 0);
        wait_drained();
        end_test("station move");

        repeat (50) @(posedge clock);
        errors += switch_core_i.checker_i.failures;
        $display("Tests %0d, with errors %0d, frames checked %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+hdl
hdl/switch_pkg.sv
hdl/port_rx_queue.sv
hdl/cam_table.sv
hdl/core_data_orchestrator.sv
hdl/egress_fanout.sv
hdl/switch_core.sv
verif/tb_clock_gen.sv
verif/switch_core_checker.sv
verif/switch_core_tb.sv

/* Bender.yml */
package:
  name: switch_core

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/switch_pkg.sv
      - hdl/port_rx_queue.sv
      - hdl/cam_table.sv
      - hdl/core_data_orchestrator.sv
      - hdl/egress_fanout.sv
      - hdl/switch_core.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - verif/tb_clock_gen.sv
      - verif/switch_core_checker.sv
      - verif/switch_core_tb.sv
